// ==== design/axi_pkg.sv ====
package axi_pkg;

  localparam int DATA_BYTES = 4;
  localparam int DATA_WIDTH = 8 * DATA_BYTES;
  localparam int ADDR_WIDTH = 6;              // byte address inside one ring
  localparam int ID_WIDTH   = 1;              // ring number
  localparam int ADDR_LSB   = $clog2(DATA_BYTES);

  localparam logic [2:0] BEAT_SIZE  = 3'(ADDR_LSB);
  localparam logic [1:0] BURST_INCR = 2'b01;
  localparam logic [1:0] RESP_OKAY  = 2'b00;

  // write address channel
  typedef struct packed {
    logic [ADDR_WIDTH-1:0] addr;
    logic [7:0]            len;   // beats minus one
    logic [2:0]            size;
    logic [1:0]            burst;
    logic [ID_WIDTH-1:0]   id;
  } aw_t;

  // write data channel
  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
    logic [DATA_BYTES-1:0] strb;
    logic                  last;
  } w_t;

  // write response channel
  typedef struct packed {
    logic [ID_WIDTH-1:0] id;
    logic [1:0]          resp;
  } b_t;

endpackage

// ==== design/ring_pkg.sv ====
package ring_pkg;

  localparam int RING_WORDS    = 16;
  localparam int MAX_BURST_LEN = 8;
  localparam int IDX_WIDTH     = $clog2(RING_WORDS);

  // word pointer, wrap bit on top of the ring index
  typedef logic [IDX_WIDTH:0] ptr_t;

  // one stream beat, tuser carries the burst length minus one
  typedef struct packed {
    logic [axi_pkg::DATA_WIDTH-1:0] tdata;
    logic [axi_pkg::DATA_BYTES-1:0] tkeep;
    logic [7:0]                     tuser;
    logic                           tlast;
  } stream_t;

  // apb map
  localparam int APB_ADDR_WIDTH = 8;
  localparam int REGION_BIT     = 7;
  localparam int DATA_RING_BIT  = 6;    // word index sits in bits 5:2
  localparam int PTR_RING_BIT   = 2;
  localparam int PTR_SEL_BIT    = 3;    // 0 write pointer, 1 read pointer

  localparam logic DATA_WINDOW = 1'b0;  // region bit values
  localparam logic PTR_BASE    = 1'b1;

endpackage

// ==== design/packet_writer.sv ====
module packet_writer (
  input  logic              aclk,
  input  logic              aresetn,
  // stream in
  input  logic              s_valid,
  output logic              s_ready,
  input  ring_pkg::stream_t s_data,
  // axi write master
  output logic              aw_valid,
  input  logic              aw_ready,
  output axi_pkg::aw_t      aw,
  output logic              w_valid,
  input  logic              w_ready,
  output axi_pkg::w_t       w,
  input  logic              b_valid,
  output logic              b_ready,
  // ring pointers
  output ring_pkg::ptr_t    wr_ptr,
  input  ring_pkg::ptr_t    rd_ptr
);
  import axi_pkg::*;
  import ring_pkg::*;

  typedef enum logic [0:0] {HEADER, DATA} state_t;

  state_t                state;
  logic                  ready_int;   // burst open, beats may pass
  logic                  start;
  logic                  beat;
  logic                  full;
  ptr_t                  wr_ptr_nxt;
  ptr_t                  delta_ptr;
  logic [ADDR_WIDTH-1:0] aw_addr;
  logic [7:0]            aw_len;

  assign beat       = w_valid && w_ready;
  assign wr_ptr_nxt = beat ? ptr_t'(wr_ptr + 1'b1) : wr_ptr;
  assign full       = delta_ptr[$high(delta_ptr)];   // room left for less than a max burst
  assign start      = (state == HEADER) && s_valid && !full;

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      state     <= HEADER;
      ready_int <= 1'b0;
      aw_valid  <= 1'b0;
      b_ready   <= 1'b0;
      wr_ptr    <= '0;
      delta_ptr <= '0;
    end else begin
      wr_ptr    <= wr_ptr_nxt;
      delta_ptr <= ptr_t'(wr_ptr_nxt + MAX_BURST_LEN - rd_ptr);

      if (aw_valid && aw_ready) begin
        aw_valid <= 1'b0;
      end

      if (b_valid && b_ready) begin
        b_ready <= 1'b0;
      end

      case (state)
        HEADER: begin
          if (start) begin
            aw_valid  <= 1'b1;
            b_ready   <= 1'b1;
            ready_int <= 1'b1;
            state     <= DATA;
          end
        end
        DATA: begin
          if (beat && w.last) begin
            ready_int <= 1'b0;
            state     <= HEADER;
          end
        end
        default: state <= HEADER;
      endcase
    end
  end

  // burst header, taken from the first beat's tuser
  always_ff @(posedge aclk) begin
    if (start) begin
      aw_addr <= ADDR_WIDTH'(wr_ptr[IDX_WIDTH-1:0]) << ADDR_LSB;
      aw_len  <= s_data.tuser;
    end
  end

  assign aw = '{
    addr:  aw_addr,
    len:   aw_len,
    size:  BEAT_SIZE,
    burst: BURST_INCR,
    id:    '0           // arbiter stamps the port
  };

  assign s_ready = w_ready && ready_int;
  assign w_valid = s_valid && ready_int;
  assign w       = '{data: s_data.tdata, strb: s_data.tkeep, last: s_data.tlast};

endmodule

// ==== design/write_arbiter.sv ====
module write_arbiter (
  input  logic                aclk,
  input  logic                aresetn,
  // master ports
  input  logic [1:0]          m_aw_valid,
  output logic [1:0]          m_aw_ready,
  input  axi_pkg::aw_t        m_aw [2],
  input  logic [1:0]          m_w_valid,
  output logic [1:0]          m_w_ready,
  input  axi_pkg::w_t         m_w [2],
  output logic [1:0]          m_b_valid,
  input  logic [1:0]          m_b_ready,
  output axi_pkg::b_t         m_b,
  // slave port
  output logic                s_aw_valid,
  input  logic                s_aw_ready,
  output axi_pkg::aw_t        s_aw,
  output logic                s_w_valid,
  input  logic                s_w_ready,
  output axi_pkg::w_t         s_w,
  input  logic                s_b_valid,
  output logic                s_b_ready,
  input  axi_pkg::b_t         s_b
);
  import axi_pkg::*;

  logic                busy;         // grant locked until wlast
  logic [ID_WIDTH-1:0] grant;
  logic [ID_WIDTH-1:0] last_grant;
  logic [ID_WIDTH-1:0] pick;
  logic                w_done;

  assign w_done = s_w_valid && s_w_ready && s_w.last;

  // round robin on ties, otherwise whoever asks
  always_comb begin
    if (&m_aw_valid) begin
      pick = ~last_grant;
    end else begin
      pick = ID_WIDTH'(m_aw_valid[1]);
    end
  end

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      busy       <= 1'b0;
      grant      <= '0;
      last_grant <= '1;
    end else begin
      if (!busy) begin
        if (|m_aw_valid) begin
          busy       <= 1'b1;
          grant      <= pick;
          last_grant <= pick;
        end
      end else if (w_done) begin
        busy <= 1'b0;
      end
    end
  end

  always_comb begin
    s_aw              = m_aw[grant];
    s_aw.id           = grant;
    s_aw_valid        = busy && m_aw_valid[grant];
    m_aw_ready        = '0;
    m_aw_ready[grant] = busy && s_aw_ready;

    s_w              = m_w[grant];
    s_w_valid        = busy && m_w_valid[grant];
    m_w_ready        = '0;
    m_w_ready[grant] = busy && s_w_ready;
  end

  // responses follow the id, independent of the current grant
  always_comb begin
    m_b_valid           = '0;
    m_b_valid[s_b.id]   = s_b_valid;
    s_b_ready           = m_b_ready[s_b.id];
  end

  assign m_b = s_b;

endmodule

// ==== design/ring_memory.sv ====
module ring_memory (
  input  logic                                aclk,
  input  logic                                aresetn,
  // axi write slave
  input  logic                                s_aw_valid,
  output logic                                s_aw_ready,
  input  axi_pkg::aw_t                        s_aw,
  input  logic                                s_w_valid,
  output logic                                s_w_ready,
  input  axi_pkg::w_t                         s_w,
  output logic                                s_b_valid,
  input  logic                                s_b_ready,
  output axi_pkg::b_t                         s_b,
  // ring pointers
  input  ring_pkg::ptr_t                      wr_ptr [2],
  output ring_pkg::ptr_t                      rd_ptr [2],
  // apb
  input  logic                                psel,
  input  logic                                penable,
  input  logic                                pwrite,
  input  logic [ring_pkg::APB_ADDR_WIDTH-1:0] paddr,
  input  logic [axi_pkg::DATA_WIDTH-1:0]      pwdata,
  output logic [axi_pkg::DATA_WIDTH-1:0]      prdata,
  output logic                                pready,
  output logic                                pslverr
);
  import axi_pkg::*;
  import ring_pkg::*;

  logic [DATA_WIDTH-1:0] mem [2*RING_WORDS];   // ring 0 then ring 1
  logic                  burst_open;
  logic [ID_WIDTH-1:0]   wr_ring;
  logic [IDX_WIDTH-1:0]  wr_idx;
  logic [ID_WIDTH-1:0]   b_id;
  logic                  aw_hs;
  logic                  w_hs;
  logic                  apb_wr;
  logic                  data_sel;
  logic                  ptr_sel;
  logic                  ptr_ring;

  assign aw_hs = s_aw_valid && s_aw_ready;
  assign w_hs  = s_w_valid && s_w_ready;

  assign s_aw_ready = !burst_open && !s_b_valid;   // hold off while B is pending
  assign s_w_ready  = burst_open;
  assign s_b        = '{id: b_id, resp: RESP_OKAY};

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      burst_open <= 1'b0;
      s_b_valid  <= 1'b0;
    end else begin
      if (aw_hs) begin
        burst_open <= 1'b1;
      end else if (w_hs && s_w.last) begin
        burst_open <= 1'b0;
        s_b_valid  <= 1'b1;
      end
      if (s_b_valid && s_b_ready) begin
        s_b_valid <= 1'b0;
      end
    end
  end

  // word address wraps inside the ring
  always_ff @(posedge aclk) begin
    if (aw_hs) begin
      wr_ring <= s_aw.id;
      wr_idx  <= s_aw.addr[ADDR_LSB +: IDX_WIDTH];
    end else if (w_hs) begin
      wr_idx <= wr_idx + 1'b1;
      for (int i = 0; i < DATA_BYTES; i++) begin
        if (s_w.strb[i]) begin
          mem[{wr_ring, wr_idx}][8*i +: 8] <= s_w.data[8*i +: 8];
        end
      end
      if (s_w.last) begin
        b_id <= wr_ring;
      end
    end
  end

  assign apb_wr   = psel && penable && pwrite;
  assign data_sel = paddr[REGION_BIT] == DATA_WINDOW;
  assign ptr_sel  = paddr[REGION_BIT] == PTR_BASE;
  assign ptr_ring = paddr[PTR_RING_BIT];
  assign pready   = 1'b1;
  assign pslverr  = apb_wr && data_sel;   // data window is read only

  // host frees space by moving the read pointer
  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      rd_ptr <= '{default: '0};
    end else if (apb_wr && ptr_sel && paddr[PTR_SEL_BIT]) begin
      rd_ptr[ptr_ring] <= pwdata[IDX_WIDTH:0];
    end
  end

  always_comb begin
    if (data_sel) begin
      prdata = mem[{paddr[DATA_RING_BIT], paddr[ADDR_LSB +: IDX_WIDTH]}];
    end else if (paddr[PTR_SEL_BIT]) begin
      prdata = DATA_WIDTH'(rd_ptr[ptr_ring]);
    end else begin
      prdata = DATA_WIDTH'(wr_ptr[ptr_ring]);
    end
  end

endmodule

// ==== design/packet_buffer_top.sv ====
module packet_buffer_top (
  input  logic                                aclk,
  input  logic                                aresetn,
  // capture channels
  input  logic                                s0_valid,
  output logic                                s0_ready,
  input  ring_pkg::stream_t                   s0_data,
  input  logic                                s1_valid,
  output logic                                s1_ready,
  input  ring_pkg::stream_t                   s1_data,
  // host
  input  logic                                psel,
  input  logic                                penable,
  input  logic                                pwrite,
  input  logic [ring_pkg::APB_ADDR_WIDTH-1:0] paddr,
  input  logic [axi_pkg::DATA_WIDTH-1:0]      pwdata,
  output logic [axi_pkg::DATA_WIDTH-1:0]      prdata,
  output logic                                pready,
  output logic                                pslverr
);
  import axi_pkg::*;
  import ring_pkg::*;

  logic [1:0] s_valid, s_ready;
  stream_t    s_data [2];
  logic [1:0] m_aw_valid, m_aw_ready, m_w_valid, m_w_ready, m_b_valid, m_b_ready;
  aw_t        m_aw [2];
  w_t         m_w [2];
  logic       aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready;
  aw_t        aw;
  w_t         w;
  b_t         b;
  ptr_t       wr_ptr [2];
  ptr_t       rd_ptr [2];

  assign s_valid  = {s1_valid, s0_valid};
  assign s_data   = '{s0_data, s1_data};
  assign s0_ready = s_ready[0];
  assign s1_ready = s_ready[1];

  for (genvar i = 0; i < 2; i++) begin : g_writer
    packet_writer i_packet_writer (
      .aclk     (aclk),
      .aresetn  (aresetn),
      .s_valid  (s_valid[i]),
      .s_ready  (s_ready[i]),
      .s_data   (s_data[i]),
      .aw_valid (m_aw_valid[i]),
      .aw_ready (m_aw_ready[i]),
      .aw       (m_aw[i]),
      .w_valid  (m_w_valid[i]),
      .w_ready  (m_w_ready[i]),
      .w        (m_w[i]),
      .b_valid  (m_b_valid[i]),
      .b_ready  (m_b_ready[i]),
      .wr_ptr   (wr_ptr[i]),
      .rd_ptr   (rd_ptr[i])
    );
  end

  write_arbiter i_write_arbiter (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .m_aw_valid (m_aw_valid),
    .m_aw_ready (m_aw_ready),
    .m_aw       (m_aw),
    .m_w_valid  (m_w_valid),
    .m_w_ready  (m_w_ready),
    .m_w        (m_w),
    .m_b_valid  (m_b_valid),
    .m_b_ready  (m_b_ready),
    .m_b        (),            // writers only count the handshake
    .s_aw_valid (aw_valid),
    .s_aw_ready (aw_ready),
    .s_aw       (aw),
    .s_w_valid  (w_valid),
    .s_w_ready  (w_ready),
    .s_w        (w),
    .s_b_valid  (b_valid),
    .s_b_ready  (b_ready),
    .s_b        (b)
  );

  ring_memory i_ring_memory (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .s_aw_valid (aw_valid),
    .s_aw_ready (aw_ready),
    .s_aw       (aw),
    .s_w_valid  (w_valid),
    .s_w_ready  (w_ready),
    .s_w        (w),
    .s_b_valid  (b_valid),
    .s_b_ready  (b_ready),
    .s_b        (b),
    .wr_ptr     (wr_ptr),
    .rd_ptr     (rd_ptr),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr)
  );

endmodule

// ==== tb/tb_clock.sv ====
module tb_clock (
  output logic aclk,
  output logic aresetn
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int HALF_PERIOD = 10;   // 20 ns clock

  initial begin
    aclk = 1'b0;
    forever #(HALF_PERIOD) aclk = ~aclk;
  end

  initial begin
    aresetn = 1'b0;
    repeat (3) @(posedge aclk);
    @(negedge aclk);
    aresetn = 1'b1;   // release away from the rising edge
  end

endmodule

// ==== tb/packet_buffer_tb.sv ====
module packet_buffer_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import axi_pkg::*;
  import ring_pkg::*;

  localparam int CLK_PERIOD = 20;
  localparam int MAX_BEATS  = 4 + 2 * 3 + 2 * MAX_BURST_LEN;
  localparam int TIMEOUT    = (MAX_BEATS * 20 + 400) * CLK_PERIOD;

  logic                  aclk;
  logic                  aresetn;
  logic [1:0]            s_valid;
  logic [1:0]            s_ready;
  stream_t               s_data [2];
  logic                  psel;
  logic                  penable;
  logic                  pwrite;
  logic [7:0]            paddr;
  logic [DATA_WIDTH-1:0] pwdata;
  logic [DATA_WIDTH-1:0] prdata;
  logic                  pready;
  logic                  pslverr;
  stream_t               sent [2][64];   // every accepted beat, per ring
  int                    sent_cnt [2];
  int                    errors;
  int                    checks;

  tb_clock i_tb_clock (.aclk(aclk), .aresetn(aresetn));

  packet_buffer_top i_packet_buffer_top (
    .aclk     (aclk),
    .aresetn  (aresetn),
    .s0_valid (s_valid[0]),
    .s0_ready (s_ready[0]),
    .s0_data  (s_data[0]),
    .s1_valid (s_valid[1]),
    .s1_ready (s_ready[1]),
    .s1_data  (s_data[1]),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .paddr    (paddr),
    .pwdata   (pwdata),
    .prdata   (prdata),
    .pready   (pready),
    .pslverr  (pslverr)
  );

  function automatic logic [7:0] ptr_addr(input int ring, input int rd);
    return {1'b1, 3'b000, rd[0], ring[0], 2'b00};
  endfunction

  function automatic logic [7:0] data_addr(input int ring, input int idx);
    return {1'b0, ring[0], idx[3:0], 2'b00};
  endfunction

  // beat k of a ring lands at word k mod RING_WORDS and later beats win
  function automatic logic [DATA_WIDTH-1:0] expected_word(input int ring, input int idx);
    logic [DATA_WIDTH-1:0] word;
    word = 'x;
    for (int k = 0; k < sent_cnt[ring]; k++) begin
      if (k % RING_WORDS == idx) begin
        for (int b = 0; b < DATA_BYTES; b++) begin
          if (sent[ring][k].tkeep[b]) begin
            word[8*b +: 8] = sent[ring][k].tdata[8*b +: 8];
          end
        end
      end
    end
    return word;
  endfunction

  function automatic ptr_t expected_ptr(input int ring);
    return ptr_t'(sent_cnt[ring]);
  endfunction

  task automatic check_word(input string name, input logic [DATA_WIDTH-1:0] got,
                            input logic [DATA_WIDTH-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_ptr(input string name, input ptr_t got, input ptr_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [DATA_WIDTH-1:0] data,
                           output logic err);
    @(negedge aclk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(negedge aclk);
    penable = 1'b1;
    @(negedge aclk);
    err     = pslverr;   // access completed on the rising edge before
    check_bit("pready", pready, 1'b1);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [DATA_WIDTH-1:0] data);
    @(negedge aclk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    @(negedge aclk);
    penable = 1'b1;
    data    = prdata;    // access cycle
    check_bit("pready", pready, 1'b1);
    @(negedge aclk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  // one packet with tuser held on every beat
  task automatic send_packet(input int ch, input int len);
    stream_t beat;
    for (int i = 0; i < len; i++) begin
      beat.tdata = $urandom;
      beat.tkeep = '1;
      beat.tuser = 8'(len - 1);
      beat.tlast = (i == len - 1);
      @(negedge aclk);
      s_valid[ch] = 1'b1;
      s_data[ch]  = beat;
      while (!s_ready[ch]) @(negedge aclk);
      sent[ch][sent_cnt[ch]] = beat;
      sent_cnt[ch]++;
    end
    @(negedge aclk);
    s_valid[ch] = 1'b0;
  endtask

  // reads back every word still held by the ring and its write pointer
  task automatic check_ring(input int ring);
    logic [DATA_WIDTH-1:0] rdata;
    int                    first;
    first = (sent_cnt[ring] > RING_WORDS) ? sent_cnt[ring] - RING_WORDS : 0;
    for (int k = first; k < sent_cnt[ring]; k++) begin
      apb_read(data_addr(ring, k % RING_WORDS), rdata);
      check_word($sformatf("ring%0d word %0d", ring, k % RING_WORDS), rdata,
                 expected_word(ring, k % RING_WORDS));
    end
    apb_read(ptr_addr(ring, 0), rdata);
    check_ptr($sformatf("wr_ptr%0d", ring), ptr_t'(rdata), expected_ptr(ring));
  endtask

  task automatic free_ring(input int ring);
    logic err;
    apb_write(ptr_addr(ring, 1), DATA_WIDTH'(expected_ptr(ring)), err);
    check_bit("pslverr on rd_ptr write", err, 1'b0);
  endtask

  initial begin
    #(TIMEOUT);
    $display("watchdog expired after %0d ns, a stream or apb handshake hung", TIMEOUT);
    $display("test failed");
    $finish;
  end

  initial begin
    logic [DATA_WIDTH-1:0] rdata;
    logic                  err;
    ptr_t                  ptr_before;
    void'($urandom(32'h84f58cf1));
    s_valid = '0;
    s_data  = '{default: '0};
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    wait (aresetn);
    @(negedge aclk);

    check_bit("s0_ready", s_ready[0], 1'b0);
    check_bit("s1_ready", s_ready[1], 1'b0);
    for (int r = 0; r < 2; r++) begin
      for (int p = 0; p < 2; p++) begin
        apb_read(ptr_addr(r, p), rdata);
        check_ptr($sformatf("ptr reg ring%0d sel%0d", r, p), ptr_t'(rdata), '0);
      end
    end

    // short packets keep ring 0 below half so the stalled burst later wraps
    send_packet(0, $urandom_range(MAX_BURST_LEN / 2, 1));
    check_ring(0);
    free_ring(0);

    fork
      send_packet(0, $urandom_range(3, 1));
      send_packet(1, $urandom_range(3, 1));
    join
    check_ring(0);
    check_ring(1);
    free_ring(0);
    free_ring(1);

    send_packet(0, MAX_BURST_LEN);   // ring 0 now counts as full
    ptr_before = expected_ptr(0);
    fork
      send_packet(0, MAX_BURST_LEN);
      begin
        repeat (20) @(negedge aclk);
        check_ptr("beats taken while full", ptr_t'(sent_cnt[0]), ptr_before);
        apb_read(ptr_addr(0, 0), rdata);
        check_ptr("wr_ptr0 while full", ptr_t'(rdata), ptr_before);
        free_ring(0);
      end
    join
    check_ring(0);

    apb_write(data_addr(0, 0), ~expected_word(0, 0), err);
    check_bit("pslverr", err, 1'b1);
    apb_read(data_addr(0, 0), rdata);
    check_word("ring0 word 0 after host write", rdata, expected_word(0, 0));

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// ==== src.f ====
design/axi_pkg.sv
design/ring_pkg.sv
design/packet_writer.sv
design/write_arbiter.sv
design/ring_memory.sv
design/packet_buffer_top.sv
tb/tb_clock.sv
tb/packet_buffer_tb.sv
